/* run_sim.sh */
#!/bin/sh
# Build and run the crosspoint testbench, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module xp_tb -f xp.f -o xp_sim &&
./obj_dir/xp_sim | tee /dev/stderr | grep -q "=== PASS ===" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* source/xp_id_remap.sv */
`timescale 1ns/1ps

module xp_id_remap (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  xp_pkg::xbar_ar_chan_t slv_ar_i,
  input  logic                  slv_ar_valid_i,
  output logic                  slv_ar_ready_o,
  output xp_pkg::xbar_r_chan_t  slv_r_o,
  output logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,
  output xp_pkg::ar_chan_t      mst_ar_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  input  xp_pkg::r_chan_t       mst_r_i,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o
);

  // Slot table, the slot number is the narrow ID
  logic             [xp_pkg::REMAP_SLOTS-1:0] slot_valid_q;
  xp_pkg::xbar_id_u [xp_pkg::REMAP_SLOTS-1:0] slot_id_q;

  logic        id_hit;
  logic        table_full;
  xp_pkg::id_t free_slot;
  xp_pkg::id_t alloc_slot;
  // Slot chosen for a request that waits for ready
  logic        alloc_lock_q;
  xp_pkg::id_t alloc_slot_q;
  logic        ar_fire;
  logic        r_fire;

  always_comb begin
    id_hit    = 1'b0;
    free_slot = '0;
    // Same wide ID in flight, must wait to keep its responses ordered
    for (int i = 0; i < xp_pkg::REMAP_SLOTS; i++) begin
      if (slot_valid_q[i] && (slot_id_q[i].raw == slv_ar_i.id.raw)) id_hit = 1'b1;
    end
    // Scan downwards so the lowest free slot is picked
    for (int i = xp_pkg::REMAP_SLOTS - 1; i >= 0; i--) begin
      if (!slot_valid_q[i]) free_slot = xp_pkg::id_t'(i);
    end
  end

  assign table_full = &slot_valid_q;

  // A lower slot may free up while the request stalls, the narrow ID must not move
  assign alloc_slot = alloc_lock_q ? alloc_slot_q : free_slot;

  // AR passes straight through unless the table blocks it
  assign mst_ar_valid_o = slv_ar_valid_i && !id_hit && !table_full;
  assign slv_ar_ready_o = mst_ar_ready_i && !id_hit && !table_full;
  assign mst_ar_o       = '{id: alloc_slot, addr: slv_ar_i.addr};
  assign ar_fire        = mst_ar_valid_o && mst_ar_ready_i;

  // R restores the wide ID stored in the slot
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;
  assign slv_r_o       = '{id:   slot_id_q[mst_r_i.id],
                           data: mst_r_i.data,
                           resp: mst_r_i.resp};
  assign r_fire        = mst_r_valid_i && slv_r_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid_q <= '0;
      alloc_lock_q <= 1'b0;
    end else begin
      alloc_lock_q <= mst_ar_valid_o && !mst_ar_ready_i;
      // Freed and allocated slots never collide, one is valid and one is not
      if (r_fire) slot_valid_q[mst_r_i.id] <= 1'b0;
      if (ar_fire) slot_valid_q[alloc_slot] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    alloc_slot_q <= alloc_slot;
    if (ar_fire) slot_id_q[alloc_slot] <= slv_ar_i.id;
  end

endmodule

/* source/xp_pkg.sv */
package xp_pkg;

  // Port counts
  localparam int unsigned NUM_SLV_PORTS  = 2;
  localparam int unsigned NUM_MST_PORTS  = 2;

  // Bus widths
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned ID_WIDTH       = 2;

  // Index widths used to widen the ID and to select a master port
  localparam int unsigned SLV_IDX_WIDTH  = $clog2(NUM_SLV_PORTS);
  localparam int unsigned MST_IDX_WIDTH  = $clog2(NUM_MST_PORTS);
  localparam int unsigned XBAR_ID_WIDTH  = ID_WIDTH + SLV_IDX_WIDTH;

  // Address map size
  localparam int unsigned NUM_ADDR_RULES = 2;

  // One slot per narrow ID value
  localparam int unsigned REMAP_SLOTS    = 2 ** ID_WIDTH;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ID_WIDTH-1:0]   id_t;

  // AXI response code
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Wide ID split into originating slave port and the ID issued there
  typedef struct packed {
    logic [SLV_IDX_WIDTH-1:0] slv_idx;
    id_t                      orig_id;
  } xbar_id_fields_t;

  typedef union packed {
    logic [XBAR_ID_WIDTH-1:0] raw;
    xbar_id_fields_t          fields;
  } xbar_id_u;

  // Read address channel, port ID width
  typedef struct packed {
    id_t   id;
    addr_t addr;
  } ar_chan_t;

  // Read data channel, port ID width
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
  } r_chan_t;

  // Read channels between crossbar and remappers
  typedef struct packed {
    xbar_id_u id;
    addr_t    addr;
  } xbar_ar_chan_t;

  typedef struct packed {
    xbar_id_u id;
    data_t    data;
    resp_t    resp;
  } xbar_r_chan_t;

  // Address rule, end_addr is exclusive
  typedef struct packed {
    addr_t                    start_addr;
    addr_t                    end_addr;
    logic [MST_IDX_WIDTH-1:0] mst_idx;
  } rule_t;

endpackage

/* source/xp_rr_arbiter.sv */
`timescale 1ns/1ps

module xp_rr_arbiter (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic [1:0] req_i,
  input  logic       hold_i,
  output logic [1:0] gnt_o
);

  // Port that wins a tie on the next fresh decision
  logic       prio_q;
  // Grant frozen while the granted transfer stalls
  logic       lock_q;
  logic [1:0] gnt_q;
  logic [1:0] gnt_new;

  // Fresh decision from the priority pointer
  always_comb begin
    gnt_new = 2'b00;
    if (prio_q == 1'b0) begin
      if (req_i[0]) gnt_new = 2'b01;
      else if (req_i[1]) gnt_new = 2'b10;
    end else begin
      if (req_i[1]) gnt_new = 2'b10;
      else if (req_i[0]) gnt_new = 2'b01;
    end
  end

  // A stalled request keeps its grant even if the other port shows up
  assign gnt_o = lock_q ? (gnt_q & req_i) : gnt_new;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= 1'b0;
      lock_q <= 1'b0;
      gnt_q  <= 2'b00;
    end else begin
      lock_q <= hold_i && (gnt_o != 2'b00);
      gnt_q  <= gnt_o;
      // Completed transfer hands priority to the other port
      if ((gnt_o != 2'b00) && !hold_i) begin
        prio_q <= gnt_o[0];
      end
    end
  end

endmodule

/* source/xp_top.sv */
`timescale 1ns/1ps

module xp_top (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  xp_pkg::rule_t         [xp_pkg::NUM_ADDR_RULES-1:0] addr_map_i,
  input  xp_pkg::ar_chan_t      [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_i,
  input  logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_valid_i,
  output logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_ready_o,
  output xp_pkg::r_chan_t       [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_o,
  output logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_valid_o,
  input  logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_ready_i,
  output xp_pkg::ar_chan_t      [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_o,
  output logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_valid_o,
  input  logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_ready_i,
  input  xp_pkg::r_chan_t       [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_i,
  input  logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_valid_i,
  output logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_ready_o
);

  // Wide-ID channels between crossbar and remappers
  xp_pkg::xbar_ar_chan_t [xp_pkg::NUM_MST_PORTS-1:0] xbar_ar;
  logic                  [xp_pkg::NUM_MST_PORTS-1:0] xbar_ar_valid;
  logic                  [xp_pkg::NUM_MST_PORTS-1:0] xbar_ar_ready;
  xp_pkg::xbar_r_chan_t  [xp_pkg::NUM_MST_PORTS-1:0] xbar_r;
  logic                  [xp_pkg::NUM_MST_PORTS-1:0] xbar_r_valid;
  logic                  [xp_pkg::NUM_MST_PORTS-1:0] xbar_r_ready;

  xp_xbar i_xbar (
    .clk_i, .reset_i, .addr_map_i,
    .slv_ar_i, .slv_ar_valid_i, .slv_ar_ready_o,
    .slv_r_o, .slv_r_valid_o, .slv_r_ready_i,
    .mst_ar_o ( xbar_ar ), .mst_ar_valid_o ( xbar_ar_valid ), .mst_ar_ready_i ( xbar_ar_ready ),
    .mst_r_i  ( xbar_r  ), .mst_r_valid_i  ( xbar_r_valid  ), .mst_r_ready_o  ( xbar_r_ready  )
  );

  // Narrow the IDs back to port width at each master port
  for (genvar m = 0; m < xp_pkg::NUM_MST_PORTS; m++) begin : gen_remap
    xp_id_remap i_id_remap (
      .clk_i, .reset_i,
      .slv_ar_i ( xbar_ar[m] ), .slv_ar_valid_i ( xbar_ar_valid[m] ),
      .slv_ar_ready_o ( xbar_ar_ready[m] ),
      .slv_r_o ( xbar_r[m] ), .slv_r_valid_o ( xbar_r_valid[m] ),
      .slv_r_ready_i ( xbar_r_ready[m] ),
      .mst_ar_o ( mst_ar_o[m] ), .mst_ar_valid_o ( mst_ar_valid_o[m] ),
      .mst_ar_ready_i ( mst_ar_ready_i[m] ),
      .mst_r_i ( mst_r_i[m] ), .mst_r_valid_i ( mst_r_valid_i[m] ),
      .mst_r_ready_o ( mst_r_ready_o[m] )
    );
  end

endmodule

/* source/xp_xbar.sv */
`timescale 1ns/1ps

module xp_xbar (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  xp_pkg::rule_t         [xp_pkg::NUM_ADDR_RULES-1:0] addr_map_i,
  input  xp_pkg::ar_chan_t      [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_i,
  input  logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_valid_i,
  output logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_ready_o,
  output xp_pkg::r_chan_t       [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_o,
  output logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_valid_o,
  input  logic                  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_ready_i,
  output xp_pkg::xbar_ar_chan_t [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_o,
  output logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_valid_o,
  input  logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_ready_i,
  input  xp_pkg::xbar_r_chan_t  [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_i,
  input  logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_valid_i,
  output logic                  [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_ready_o
);

  // Address decode result per slave port
  logic [xp_pkg::NUM_SLV_PORTS-1:0]                            dec_match;
  logic [xp_pkg::NUM_SLV_PORTS-1:0][xp_pkg::MST_IDX_WIDTH-1:0] dec_mst;

  // AR arbitration, indexed [master][slave]
  logic [xp_pkg::NUM_MST_PORTS-1:0][xp_pkg::NUM_SLV_PORTS-1:0] ar_req;
  logic [xp_pkg::NUM_MST_PORTS-1:0][xp_pkg::NUM_SLV_PORTS-1:0] ar_gnt;
  logic [xp_pkg::NUM_MST_PORTS-1:0]                            ar_hold;

  // R arbitration, indexed [slave][master]
  logic [xp_pkg::NUM_SLV_PORTS-1:0][xp_pkg::NUM_MST_PORTS-1:0] r_req;
  logic [xp_pkg::NUM_SLV_PORTS-1:0][xp_pkg::NUM_MST_PORTS-1:0] r_gnt;
  logic [xp_pkg::NUM_SLV_PORTS-1:0]                            r_hold;

  // One-entry decode-error responder per slave port
  logic        [xp_pkg::NUM_SLV_PORTS-1:0] derr_valid_q;
  logic        [xp_pkg::NUM_SLV_PORTS-1:0] derr_lock_q;
  logic        [xp_pkg::NUM_SLV_PORTS-1:0] derr_sel;
  logic        [xp_pkg::NUM_SLV_PORTS-1:0] derr_take;
  xp_pkg::id_t [xp_pkg::NUM_SLV_PORTS-1:0] derr_id_q;

  // Address decode
  always_comb begin
    for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
      dec_match[s] = 1'b0;
      dec_mst[s]   = '0;
      // Walk rules backwards so the lowest matching index is left standing
      for (int r = xp_pkg::NUM_ADDR_RULES - 1; r >= 0; r--) begin
        if ((slv_ar_i[s].addr >= addr_map_i[r].start_addr) &&
            (slv_ar_i[s].addr < addr_map_i[r].end_addr)) begin
          dec_match[s] = 1'b1;
          dec_mst[s]   = addr_map_i[r].mst_idx;
        end
      end
    end
  end

  // Requests towards each master port
  always_comb begin
    for (int m = 0; m < xp_pkg::NUM_MST_PORTS; m++) begin
      for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
        ar_req[m][s] = slv_ar_valid_i[s] && dec_match[s] && (int'(dec_mst[s]) == m);
      end
    end
  end

  // Mapped requests wait for their master, unmapped ones for the error slot
  always_comb begin
    for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
      if (dec_match[s]) begin
        slv_ar_ready_o[s] = ar_gnt[dec_mst[s]][s] && mst_ar_ready_i[dec_mst[s]];
      end else begin
        slv_ar_ready_o[s] = !derr_valid_q[s];
      end
      derr_take[s] = slv_ar_valid_i[s] && !dec_match[s] && !derr_valid_q[s];
    end
  end

  for (genvar m = 0; m < xp_pkg::NUM_MST_PORTS; m++) begin : gen_mst
    logic [xp_pkg::SLV_IDX_WIDTH-1:0] ar_src;
    xp_pkg::xbar_id_u                 ar_id;

    xp_rr_arbiter i_ar_arb (
      .clk_i   ( clk_i      ),
      .reset_i ( reset_i    ),
      .req_i   ( ar_req[m]  ),
      .hold_i  ( ar_hold[m] ),
      .gnt_o   ( ar_gnt[m]  )
    );

    // With two slave ports the upper grant bit is the source index
    assign ar_src            = ar_gnt[m][1];
    assign mst_ar_valid_o[m] = |ar_gnt[m];
    assign ar_hold[m]        = mst_ar_valid_o[m] && !mst_ar_ready_i[m];

    // Widen the ID with the slave port it came from
    assign ar_id.fields = '{slv_idx: ar_src, orig_id: slv_ar_i[ar_src].id};
    assign mst_ar_o[m]  = '{id: ar_id, addr: slv_ar_i[ar_src].addr};
  end

  // Route each R beat by the slave index in its wide ID
  always_comb begin
    for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
      for (int m = 0; m < xp_pkg::NUM_MST_PORTS; m++) begin
        r_req[s][m] = mst_r_valid_i[m] && !derr_lock_q[s] &&
                      (int'(mst_r_i[m].id.fields.slv_idx) == s);
      end
    end
  end

  // Losing master ports see ready low and stall
  always_comb begin
    for (int m = 0; m < xp_pkg::NUM_MST_PORTS; m++) begin
      mst_r_ready_o[m] = 1'b0;
      for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
        if (r_gnt[s][m] && slv_r_ready_i[s]) mst_r_ready_o[m] = 1'b1;
      end
    end
  end

  for (genvar s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin : gen_slv
    logic [xp_pkg::MST_IDX_WIDTH-1:0] r_src;
    xp_pkg::r_chan_t                  mst_beat;
    xp_pkg::r_chan_t                  derr_beat;

    xp_rr_arbiter i_r_arb (
      .clk_i   ( clk_i     ),
      .reset_i ( reset_i   ),
      .req_i   ( r_req[s]  ),
      .hold_i  ( r_hold[s] ),
      .gnt_o   ( r_gnt[s]  )
    );

    assign r_src     = r_gnt[s][1];
    assign r_hold[s] = (|r_gnt[s]) && !slv_r_ready_i[s];

    // Error response has the lowest priority, only idle cycles serve it
    assign derr_sel[s]      = derr_valid_q[s] && (r_gnt[s] == '0);
    assign slv_r_valid_o[s] = (|r_gnt[s]) || derr_sel[s];

    // Narrow the ID back to what the slave port issued
    assign mst_beat  = '{id:   mst_r_i[r_src].id.fields.orig_id,
                         data: mst_r_i[r_src].data,
                         resp: mst_r_i[r_src].resp};
    assign derr_beat = '{id: derr_id_q[s], data: '0, resp: xp_pkg::RESP_DECERR};
    assign slv_r_o[s] = derr_sel[s] ? derr_beat : mst_beat;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      derr_valid_q <= '0;
      derr_lock_q  <= '0;
    end else begin
      for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
        // A stalled error beat keeps master beats out of the way
        derr_lock_q[s] <= derr_sel[s] && !slv_r_ready_i[s];
        if (derr_sel[s] && slv_r_ready_i[s]) derr_valid_q[s] <= 1'b0;
        else if (derr_take[s]) derr_valid_q[s] <= 1'b1;
      end
    end
  end

  // Original ID of the rejected read
  always_ff @(posedge clk_i) begin
    for (int s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin
      if (derr_take[s]) derr_id_q[s] <= slv_ar_i[s].id;
    end
  end

endmodule

/* tb/xp_sva.sv */
`timescale 1ns/1ps

module xp_sva (
  input logic                                               clk_i,
  input logic                                               reset_i,
  input xp_pkg::r_chan_t  [xp_pkg::NUM_SLV_PORTS-1:0] slv_r_o,
  input logic             [xp_pkg::NUM_SLV_PORTS-1:0] slv_r_valid_o,
  input logic             [xp_pkg::NUM_SLV_PORTS-1:0] slv_r_ready_i,
  input xp_pkg::ar_chan_t [xp_pkg::NUM_MST_PORTS-1:0] mst_ar_o,
  input logic             [xp_pkg::NUM_MST_PORTS-1:0] mst_ar_valid_o,
  input logic             [xp_pkg::NUM_MST_PORTS-1:0] mst_ar_ready_i
);

  // R beat towards a slave port holds until taken
  for (genvar s = 0; s < xp_pkg::NUM_SLV_PORTS; s++) begin : gen_slv
    r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      slv_r_valid_o[s] && !slv_r_ready_i[s] |=> slv_r_valid_o[s] && $stable(slv_r_o[s]))
      else $error("slave %0d R beat changed before ready", s);
  end

  // AR at a master port holds until taken
  for (genvar m = 0; m < xp_pkg::NUM_MST_PORTS; m++) begin : gen_mst
    ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      mst_ar_valid_o[m] && !mst_ar_ready_i[m] |=> mst_ar_valid_o[m] && $stable(mst_ar_o[m]))
      else $error("master %0d AR request changed before ready", m);
  end

  // Synchronous reset clears state after its first edge
  reset_quiet: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> (slv_r_valid_o == '0) && (mst_ar_valid_o == '0))
    else $error("valid output high during reset");

endmodule

bind xp_top xp_sva i_sva (
  .clk_i(clk_i), .reset_i(reset_i),
  .slv_r_o(slv_r_o), .slv_r_valid_o(slv_r_valid_o), .slv_r_ready_i(slv_r_ready_i),
  .mst_ar_o(mst_ar_o), .mst_ar_valid_o(mst_ar_valid_o), .mst_ar_ready_i(mst_ar_ready_i)
);

/* tb/xp_tb.sv */
`timescale 1ns/1ps

module xp_tb;

  localparam int NUM_TESTS = 12;
  localparam int FIELDS    = 5;
  localparam int TIMEOUT   = NUM_TESTS * 40 + 100;
  // Slave-side R ready is held low this long after reset
  localparam int BP_CYCLES = 40;
  localparam int DEPTH     = 8;

  logic                                                      clk_i = 1'b0;
  logic                                                      reset_i;
  xp_pkg::rule_t    [xp_pkg::NUM_ADDR_RULES-1:0] addr_map_i;
  xp_pkg::ar_chan_t [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_i;
  logic             [xp_pkg::NUM_SLV_PORTS-1:0]  slv_ar_valid_i, slv_ar_ready_o;
  xp_pkg::r_chan_t  [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_o;
  logic             [xp_pkg::NUM_SLV_PORTS-1:0]  slv_r_valid_o, slv_r_ready_i;
  xp_pkg::ar_chan_t [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_o;
  logic             [xp_pkg::NUM_MST_PORTS-1:0]  mst_ar_valid_o, mst_ar_ready_i;
  xp_pkg::r_chan_t  [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_i;
  logic             [xp_pkg::NUM_MST_PORTS-1:0]  mst_r_valid_i, mst_r_ready_o;

  // Columns per test: slave port, ID, address, expected master, expected response
  logic [31:0] test_mem [0:NUM_TESTS*FIELDS-1];
  bit          issued [NUM_TESTS];
  bit          done [NUM_TESTS];
  int          cur_test [2];
  bit          ar_busy [2];
  // Memory model entries per master port
  bit          ent_valid [2][DEPTH];
  int          ent_test [2][DEPTH];
  int          ent_due [2][DEPTH];
  logic [1:0]  ent_id [2][DEPTH];
  logic [31:0] ent_addr [2][DEPTH];
  bit          pres_busy [2];
  int          pres_idx [2];
  int          cycle, errors, n_done;
  logic [31:0] lcg_state = 32'd88999;

  xp_top dut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic int field(int t, int k);
    return int'(test_mem[t*FIELDS+k]);
  endfunction

  // Unmapped reads return zero, mapped ones the address with the master in the top byte
  function automatic logic [31:0] expected_data(int t);
    if (field(t, 4) == 3) return 32'h0;
    return test_mem[t*FIELDS+2] ^ (test_mem[t*FIELDS+3] << 24);
  endfunction

  function automatic int next_test_for(int s, int from);
    for (int t = from; t < NUM_TESTS; t++) if (field(t, 0) == s) return t;
    return NUM_TESTS;
  endfunction

  function automatic int test_by_addr(logic [31:0] a);
    for (int t = 0; t < NUM_TESTS; t++) if (test_mem[t*FIELDS+2] == a) return t;
    return -1;
  endfunction

  task automatic drive_slaves();
    for (int s = 0; s < 2; s++) begin
      if (ar_busy[s] && slv_ar_valid_i[s] && slv_ar_ready_o[s]) begin
        issued[cur_test[s]] = 1'b1;
        ar_busy[s] = 1'b0;
        slv_ar_valid_i[s] <= 1'b0;
        cur_test[s] = next_test_for(s, cur_test[s] + 1);
      end
      if (!ar_busy[s] && cur_test[s] < NUM_TESTS) begin
        slv_ar_i[s] <= '{id: xp_pkg::id_t'(field(cur_test[s], 1)),
                         addr: test_mem[cur_test[s]*FIELDS+2]};
        slv_ar_valid_i[s] <= 1'b1;
        ar_busy[s] = 1'b1;
      end
      slv_r_ready_i[s] <= (cycle < BP_CYCLES) ? 1'b0 : (lcg_next() % 4 != 0);
    end
  endtask

  // Scoreboard keyed by slave port and ID, data picks among same-ID reads
  task automatic collect_responses();
    int hit;
    for (int s = 0; s < 2; s++) begin
      if (slv_r_valid_o[s] && slv_r_ready_i[s]) begin
        hit = -1;
        for (int t = 0; t < NUM_TESTS; t++) begin
          if (hit < 0 && issued[t] && !done[t] && field(t, 0) == s &&
              field(t, 1) == int'(slv_r_o[s].id) && expected_data(t) == slv_r_o[s].data)
            hit = t;
        end
        assert (hit >= 0) else begin
          errors++;
          $display("ERROR %0t: slave %0d id %0d data %h matches no read in flight",
                   $time, s, slv_r_o[s].id, slv_r_o[s].data);
        end
        if (hit >= 0) begin
          done[hit] = 1'b1;
          n_done++;
          assert (int'(slv_r_o[s].resp) == field(hit, 4)) else begin
            errors++;
            $display("ERROR %0t: test %0d resp %0d, expected %0d",
                     $time, hit, slv_r_o[s].resp, field(hit, 4));
          end
        end
      end
    end
  endtask

  task automatic serve_masters();
    int t, free, cnt, pick;
    for (int m = 0; m < 2; m++) begin
      if (pres_busy[m] && mst_r_valid_i[m] && mst_r_ready_o[m]) begin
        ent_valid[m][pres_idx[m]] = 1'b0;
        pres_busy[m] = 1'b0;
        mst_r_valid_i[m] <= 1'b0;
      end
      if (mst_ar_valid_o[m] && mst_ar_ready_i[m]) begin
        t = test_by_addr(mst_ar_o[m].addr);
        free = -1;
        assert (t >= 0 && field(t, 3) == m) else begin
          errors++;
          $display("ERROR %0t: master %0d got unexpected address %h",
                   $time, m, mst_ar_o[m].addr);
        end
        for (int k = DEPTH - 1; k >= 0; k--) begin
          if (!ent_valid[m][k]) free = k;
          else if (t >= 0) begin
            // Same wide ID, or same narrow ID, must never be outstanding twice
            assert (ent_id[m][k] != mst_ar_o[m].id &&
                    !(field(ent_test[m][k], 0) == field(t, 0) &&
                      field(ent_test[m][k], 1) == field(t, 1))) else begin
              errors++;
              $display("ERROR %0t: master %0d duplicate ID in flight for test %0d",
                       $time, m, t);
            end
          end
        end
        if (free >= 0 && t >= 0) begin
          ent_valid[m][free] = 1'b1;
          ent_test[m][free]  = t;
          ent_id[m][free]    = mst_ar_o[m].id;
          ent_addr[m][free]  = mst_ar_o[m].addr;
          ent_due[m][free]   = cycle + int'(lcg_next() % 4);
        end
      end
      cnt = 0;
      for (int k = 0; k < DEPTH; k++) cnt += int'(ent_valid[m][k]);
      assert (cnt <= xp_pkg::REMAP_SLOTS) else begin
        errors++;
        $display("ERROR %0t: master %0d has %0d reads outstanding", $time, m, cnt);
      end
      // Answer a random ripe entry, which reorders across IDs
      cnt = 0;
      for (int k = 0; k < DEPTH; k++) if (ent_valid[m][k] && ent_due[m][k] <= cycle) cnt++;
      if (!pres_busy[m] && cnt > 0) begin
        pick = int'(lcg_next()) % cnt;
        for (int k = 0; k < DEPTH; k++) begin
          if (ent_valid[m][k] && ent_due[m][k] <= cycle) begin
            if (pick == 0) begin
              pres_idx[m] = k;
              pres_busy[m] = 1'b1;
              // Memory content is the address with this master index in the top byte
              mst_r_i[m] <= '{id: ent_id[m][k], data: ent_addr[m][k] ^ (32'(m) << 24),
                              resp: xp_pkg::RESP_OKAY};
              mst_r_valid_i[m] <= 1'b1;
            end
            pick--;
          end
        end
      end
      mst_ar_ready_i[m] <= (lcg_next() % 4 != 0);
    end
  endtask

  task automatic end_run(bit timed_out);
    if (timed_out) $display("Timeout after %0d cycles, %0d of %0d reads completed",
                            cycle, n_done, NUM_TESTS);
    $display("Errors: %0d, reads completed: %0d of %0d", errors, n_done, NUM_TESTS);
    if (!timed_out && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    $readmemh("tb/xp_tests.txt", test_mem);
    addr_map_i[0] = '{start_addr: 32'h0000_0000, end_addr: 32'h0001_0000, mst_idx: 1'b0};
    addr_map_i[1] = '{start_addr: 32'h0001_0000, end_addr: 32'h0002_0000, mst_idx: 1'b1};
    reset_i = 1'b1;
    slv_ar_i = '0;
    slv_ar_valid_i = '0;
    slv_r_ready_i = '0;
    mst_ar_ready_i = '0;
    mst_r_i = '0;
    mst_r_valid_i = '0;
    for (int s = 0; s < 2; s++) cur_test[s] = next_test_for(s, 0);
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
  end

  always @(posedge clk_i) begin
    if (!reset_i) begin
      cycle++;
      serve_masters();
      collect_responses();
      drive_slaves();
      if (n_done == NUM_TESTS) end_run(1'b0);
      else if (cycle >= TIMEOUT) end_run(1'b1);
    end
  end

endmodule

/* tb/xp_tests.txt */
// slave port, ID, address, expected master (2 = none), expected response (3 = DECERR)
// Addresses are unique, the memory models look tests up by address
0 0 00000100 0 0
1 0 00000200 0 0
0 1 00010100 1 0
1 1 00000300 0 0
0 2 00030000 2 3
1 2 00010200 1 0
0 0 00000400 0 0
1 0 00000500 0 0
0 3 00010300 1 0
1 3 00040000 2 3
0 0 00000600 0 0
1 1 00010400 1 0

/* xp.f */
source/xp_pkg.sv
source/xp_rr_arbiter.sv
source/xp_xbar.sv
source/xp_id_remap.sv
source/xp_top.sv
tb/xp_sva.sv
tb/xp_tb.sv
